//--- rtl/coreDefs.sv
package coreDefs;

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] RESET_VEC = '0;

    localparam logic [4:0] ALU_ADD      = 5'd0;
    localparam logic [4:0] ALU_SUB      = 5'd1;
    localparam logic [4:0] ALU_XOR      = 5'd2;
    localparam logic [4:0] ALU_OR       = 5'd3;
    localparam logic [4:0] ALU_AND      = 5'd4;
    localparam logic [4:0] ALU_SLL      = 5'd5;
    localparam logic [4:0] ALU_SRL      = 5'd6;
    localparam logic [4:0] ALU_SRA      = 5'd7;
    localparam logic [4:0] ALU_SLT      = 5'd8;
    localparam logic [4:0] ALU_SLTU     = 5'd9;
    localparam logic [4:0] ALU_RETURN_B = 5'd10; // lui passes the immediate
    localparam logic [4:0] ALU_MUL      = 5'd11;
    localparam logic [4:0] ALU_DIV      = 5'd12;
    localparam logic [4:0] ALU_DIVU     = 5'd13;
    localparam logic [4:0] ALU_REM      = 5'd14;
    localparam logic [4:0] ALU_REMU     = 5'd15;
    localparam logic [4:0] ALU_NONE     = 5'd31;

    localparam logic [2:0] WB_ALU  = 3'b000;
    localparam logic [2:0] WB_MEM  = 3'b001;
    localparam logic [2:0] WB_LINK = 3'b010; // pc + 4
    localparam logic [2:0] WB_WORD = 3'b100; // sign extend from bit 31

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG32  = 7'b0111011;
    localparam logic [6:0] OP_IMM32  = 7'b0011011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

endpackage

//--- rtl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      npcOp,
    input  logic                      pcSel,
    input  logic                      isEbreak,
    input  logic [coreDefs::XLEN-1:0] imm,
    input  logic [coreDefs::XLEN-1:0] rs1Data,
    output logic [coreDefs::XLEN-1:0] pc,
    output logic                      halted,
    output logic                      running
);
    import coreDefs::*;

    logic            started; // set by the first edge out of reset
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] nextPc;

    assign target  = pcSel ? ((rs1Data + imm) & {{(XLEN-1){1'b1}}, 1'b0}) : pc + imm;
    assign nextPc  = npcOp ? target : pc + 'd4;
    assign running = started & ~halted;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc      <= RESET_VEC;
            started <= 1'b0;
            halted  <= 1'b0;
        end else begin
            started <= 1'b1;
            if (running) begin
                pc <= nextPc;
                if (isEbreak) begin
                    halted <= 1'b1; // ebreak commits at this edge
                end
            end
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

//--- rtl/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input  logic [31:0]               inst,
    input  logic [coreDefs::XLEN-1:0] rs1Data,
    input  logic [coreDefs::XLEN-1:0] rs2Data,
    output logic [4:0]                aluOperate,
    output logic                      selA,
    output logic                      selB,
    output logic [7:0]                memoryWriteMask,
    output logic                      writeRd,
    output logic                      pcSel,
    output logic                      npcOp,
    output logic [2:0]                wbSelect,
    output logic                      memoryReadEn,
    output logic                      sext,
    output logic [3:0]                readNum,
    output logic [coreDefs::XLEN-1:0] imm,
    output logic [4:0]                rs1Addr,
    output logic [4:0]                rs2Addr,
    output logic [4:0]                rdAddr,
    output logic                      isEbreak
);
    import coreDefs::*;

    logic [6:0]      opCode;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    logic [XLEN-1:0] iImm;
    logic [XLEN-1:0] sImm;
    logic [XLEN-1:0] bImm;
    logic [XLEN-1:0] uImm;
    logic [XLEN-1:0] jImm;

    // shared by register and immediate forms, alt is inst[30]
    function automatic logic [4:0] baseAluOp(input logic [2:0] f3, input logic alt,
                                             input logic subAllowed);
        logic [4:0] op;
        case (f3)
            3'b000:  op = (alt && subAllowed) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opCode  = inst[6:0];
    assign funct7  = inst[31:25];
    assign funct3  = inst[14:12];
    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];
    assign rdAddr  = inst[11:7];

    assign iImm = {{52{inst[31]}}, inst[31:20]};
    assign sImm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign bImm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign uImm = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign jImm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign isEbreak = opCode == OP_SYSTEM && funct3 == 3'b000 && iImm == 'd1;

    always_comb begin
        aluOperate      = ALU_NONE;
        selA            = 1'b1;
        selB            = 1'b0;
        memoryWriteMask = 8'b0;
        writeRd         = 1'b0;
        pcSel           = 1'b0;
        npcOp           = 1'b0;
        wbSelect        = WB_ALU;
        memoryReadEn    = 1'b0;
        sext            = 1'b1;
        readNum         = 4'h8;
        imm             = iImm;
        case (opCode)
            OP_REG, OP_REG32: begin
                selB    = 1'b1;
                writeRd = 1'b1;
                if (opCode == OP_REG32) begin
                    wbSelect = WB_WORD;
                end
                if (funct7 == 7'b0000001) begin
                    case (funct3)
                        3'b000:  aluOperate = ALU_MUL;
                        3'b100:  aluOperate = ALU_DIV;
                        3'b101:  aluOperate = ALU_DIVU;
                        3'b110:  aluOperate = ALU_REM;
                        3'b111:  aluOperate = ALU_REMU;
                        default: aluOperate = ALU_NONE; // mulh family
                    endcase
                end else begin
                    aluOperate = baseAluOp(funct3, inst[30], 1'b1);
                end
            end
            OP_IMM, OP_IMM32: begin
                writeRd    = 1'b1;
                aluOperate = baseAluOp(funct3, inst[30], 1'b0);
                if (opCode == OP_IMM32) begin
                    wbSelect = WB_WORD;
                end
            end
            OP_AUIPC: begin
                selA       = 1'b0; // pc + imm
                writeRd    = 1'b1;
                aluOperate = ALU_ADD;
                imm        = uImm;
            end
            OP_LUI: begin
                writeRd    = 1'b1;
                aluOperate = ALU_RETURN_B;
                imm        = uImm;
            end
            OP_LOAD: begin
                writeRd      = 1'b1;
                wbSelect     = WB_MEM;
                memoryReadEn = 1'b1;
                aluOperate   = ALU_ADD;
                sext         = ~funct3[2];
                readNum      = 4'h1 << funct3[1:0];
            end
            OP_STORE: begin
                aluOperate = ALU_ADD;
                imm        = sImm;
                case (funct3)
                    3'b000:  memoryWriteMask = 8'b0000_0001;
                    3'b001:  memoryWriteMask = 8'b0000_0011;
                    3'b010:  memoryWriteMask = 8'b0000_1111;
                    3'b011:  memoryWriteMask = 8'b1111_1111;
                    default: memoryWriteMask = 8'b0;
                endcase
            end
            OP_JAL: begin
                writeRd  = 1'b1;
                npcOp    = 1'b1;
                wbSelect = WB_LINK;
                imm      = jImm;
            end
            OP_JALR: begin
                writeRd  = 1'b1;
                npcOp    = 1'b1;
                pcSel    = 1'b1; // rs1 based target
                wbSelect = WB_LINK;
            end
            OP_BRANCH: begin
                imm = bImm;
                case (funct3)
                    3'b000:  npcOp = rs1Data == rs2Data;
                    3'b001:  npcOp = rs1Data != rs2Data;
                    3'b100:  npcOp = $signed(rs1Data) < $signed(rs2Data);
                    3'b101:  npcOp = $signed(rs1Data) >= $signed(rs2Data);
                    3'b110:  npcOp = rs1Data < rs2Data;
                    3'b111:  npcOp = rs1Data >= rs2Data;
                    default: npcOp = 1'b0;
                endcase
            end
            default: ; // system and unknown opcodes write nothing
        endcase
    end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [4:0]                rs1Addr,
    input  logic [4:0]                rs2Addr,
    input  logic [4:0]                rdAddr,
    input  logic                      rdWen,
    input  logic [coreDefs::XLEN-1:0] rdData,
    output logic [coreDefs::XLEN-1:0] rs1Data,
    output logic [coreDefs::XLEN-1:0] rs2Data
);
    import coreDefs::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWen && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = regs[rs1Addr]; // x0 never leaves zero
    assign rs2Data = regs[rs2Addr];

    x0StaysZero: assert property (@(posedge clk) disable iff (!rstN)
        rdWen && rdAddr == 5'd0 |=> regs[0] == '0);

endmodule

//--- rtl/execStage.sv
`timescale 1ns/1ps

module execStage (
    input  logic [coreDefs::XLEN-1:0] pc,
    input  logic [coreDefs::XLEN-1:0] rs1Data,
    input  logic [coreDefs::XLEN-1:0] rs2Data,
    input  logic [coreDefs::XLEN-1:0] imm,
    input  logic                      selA,
    input  logic                      selB,
    input  logic [4:0]                aluOperate,
    input  logic                      wordOp,
    output logic [coreDefs::XLEN-1:0] aluResult
);
    import coreDefs::*;

    logic [XLEN-1:0]        opA;
    logic [XLEN-1:0]        opB;
    logic                   extSigned;
    logic [XLEN-1:0]        opAExt;
    logic [XLEN-1:0]        opBExt;
    logic [5:0]             shamt;
    logic                   divByZero;
    logic                   divOverflow;
    logic [XLEN-1:0]        divSafe;
    logic signed [XLEN-1:0] quotRaw;
    logic signed [XLEN-1:0] remRaw;
    logic [XLEN-1:0]        quotS;
    logic [XLEN-1:0]        remS;

    assign opA   = selA ? rs1Data : pc;
    assign opB   = selB ? rs2Data : imm;
    assign shamt = wordOp ? {1'b0, opB[4:0]} : opB[5:0];

    // word ops see only the low half, widened per signedness
    assign extSigned = aluOperate == ALU_SRA || aluOperate == ALU_DIV
                       || aluOperate == ALU_REM;

    always_comb begin
        opAExt = opA;
        opBExt = opB;
        if (wordOp) begin
            opAExt = {{32{extSigned & opA[31]}}, opA[31:0]};
            opBExt = {{32{extSigned & opB[31]}}, opB[31:0]};
        end
    end

    assign divByZero   = opBExt == '0;
    assign divOverflow = opAExt == {1'b1, {(XLEN-1){1'b0}}} && opBExt == '1;
    assign divSafe     = divByZero ? 'd1 : opBExt;

    assign quotRaw = $signed(opAExt) / $signed(divSafe); // signed context kept apart
    assign remRaw  = $signed(opAExt) % $signed(divSafe);

    assign quotS = divByZero   ? '1
                 : divOverflow ? opAExt
                 : quotRaw;
    assign remS  = divByZero   ? opAExt
                 : divOverflow ? '0
                 : remRaw;

    always_comb begin
        case (aluOperate)
            ALU_ADD:      aluResult = opA + opB;
            ALU_SUB:      aluResult = opA - opB;
            ALU_XOR:      aluResult = opA ^ opB;
            ALU_OR:       aluResult = opA | opB;
            ALU_AND:      aluResult = opA & opB;
            ALU_SLL:      aluResult = opAExt << shamt;
            ALU_SRL:      aluResult = opAExt >> shamt;
            ALU_SRA:      aluResult = $signed(opAExt) >>> shamt;
            ALU_SLT:      aluResult = XLEN'($signed(opA) < $signed(opB));
            ALU_SLTU:     aluResult = XLEN'(opA < opB);
            ALU_RETURN_B: aluResult = opB;
            ALU_MUL:      aluResult = opA * opB; // low half only
            ALU_DIV:      aluResult = quotS;
            ALU_DIVU:     aluResult = divByZero ? '1 : opAExt / divSafe;
            ALU_REM:      aluResult = remS;
            ALU_REMU:     aluResult = divByZero ? opAExt : opAExt % divSafe;
            default:      aluResult = '0;
        endcase
    end

endmodule

//--- rtl/memStage.sv
`timescale 1ns/1ps

module memStage (
    input  logic [coreDefs::XLEN-1:0] aluResult,
    input  logic [coreDefs::XLEN-1:0] rs2Data,
    input  logic [7:0]                memoryWriteMask,
    input  logic                      memoryReadEn,
    input  logic                      sext,
    input  logic [3:0]                readNum,
    input  logic                      running,
    input  logic [coreDefs::XLEN-1:0] dataReadData,
    output logic [coreDefs::XLEN-1:0] dataAddr,
    output logic [coreDefs::XLEN-1:0] dataWriteData,
    output logic [7:0]                dataWriteMask,
    output logic                      dataReadEn,
    output logic [coreDefs::XLEN-1:0] loadData
);
    import coreDefs::*;

    logic [2:0]      lane;
    logic [15:0]     wideMask;
    logic [XLEN-1:0] readShifted;

    assign lane     = aluResult[2:0]; // byte within the 8-byte word
    assign dataAddr = aluResult;

    assign wideMask      = {8'b0, memoryWriteMask} << lane;
    assign dataWriteMask = running ? wideMask[7:0] : 8'b0;
    assign dataWriteData = rs2Data << {lane, 3'b000};
    assign dataReadEn    = memoryReadEn & running;

    assign readShifted = dataReadData >> {lane, 3'b000};

    always_comb begin
        case (readNum)
            4'h1:    loadData = {{(XLEN-8){sext & readShifted[7]}}, readShifted[7:0]};
            4'h2:    loadData = {{(XLEN-16){sext & readShifted[15]}}, readShifted[15:0]};
            4'h4:    loadData = {{(XLEN-32){sext & readShifted[31]}}, readShifted[31:0]};
            default: loadData = readShifted;
        endcase
    end

    always_comb begin
        if (running) begin
            readInWord: assert final (!memoryReadEn || {1'b0, lane} + readNum <= 4'd8);
            writeInWord: assert final (wideMask[15:8] == 8'b0);
        end
    end

endmodule

//--- rtl/rvCore.sv
`timescale 1ns/1ps

module rvCore (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [31:0]               inst,
    input  logic [coreDefs::XLEN-1:0] dataReadData,
    output logic [coreDefs::XLEN-1:0] instAddr,
    output logic [coreDefs::XLEN-1:0] dataAddr,
    output logic [coreDefs::XLEN-1:0] dataWriteData,
    output logic [7:0]                dataWriteMask,
    output logic                      dataReadEn,
    output logic                      commitValid,
    output logic [coreDefs::XLEN-1:0] commitPc,
    output logic                      rdWen,
    output logic [4:0]                rdAddr,
    output logic [coreDefs::XLEN-1:0] rdData,
    output logic                      halted
);
    import coreDefs::*;

    logic [XLEN-1:0] pc;
    logic            running;
    logic [4:0]      aluOperate;
    logic            selA;
    logic            selB;
    logic [7:0]      memoryWriteMask;
    logic            writeRd;
    logic            pcSel;
    logic            npcOp;
    logic [2:0]      wbSelect;
    logic            memoryReadEn;
    logic            sext;
    logic [3:0]      readNum;
    logic [XLEN-1:0] imm;
    logic [4:0]      rs1Addr;
    logic [4:0]      rs2Addr;
    logic            isEbreak;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] loadData;
    logic            wordOp;

    fetchStage  fetchStage_i  (.*);
    instDecoder instDecoder_i (.*);
    regFile     regFile_i     (.*);
    execStage   execStage_i   (.*);
    memStage    memStage_i    (.*);

    assign instAddr    = pc;
    assign commitPc    = pc;
    assign commitValid = running;
    assign rdWen       = writeRd & running;
    assign wordOp      = wbSelect == WB_WORD; // narrows shifts and divides

    always_comb begin
        case (wbSelect)
            WB_MEM:  rdData = loadData;
            WB_LINK: rdData = pc + 'd4;
            WB_WORD: rdData = {{32{aluResult[31]}}, aluResult[31:0]};
            default: rdData = aluResult;
        endcase
    end

endmodule

//--- bench/coreTb.sv
`timescale 1ns/1ps

module coreTb;
    import coreDefs::*;

    localparam logic [31:0] EBREAK = 32'h0010_0073;

    logic            clk = 1'b0;
    logic            rstN;
    logic [31:0]     inst;
    logic [XLEN-1:0] dataReadData;
    logic [XLEN-1:0] instAddr;
    logic [XLEN-1:0] dataAddr;
    logic [XLEN-1:0] dataWriteData;
    logic [7:0]      dataWriteMask;
    logic            dataReadEn;
    logic            commitValid;
    logic [XLEN-1:0] commitPc;
    logic            rdWen;
    logic [4:0]      rdAddr;
    logic [XLEN-1:0] rdData;
    logic            halted;

    logic [31:0]     imem [256];
    logic [XLEN-1:0] dmem [256];
    logic [XLEN-1:0] shadow [32]; // register values as seen on the commit port
    logic [XLEN-1:0] pcLog [$];
    int              expRd [$];
    logic [XLEN-1:0] expVal [$];
    int              cursor;
    int              writeCount = 0;
    int              readCount = 0;
    int              checks = 0;
    int              errors = 0;
    int              testErrors;
    int              seed = 32'h6f13;

    rvCore rvCore_i (.*);

    always #20 clk = ~clk;

    assign inst         = imem[instAddr[9:2]];
    assign dataReadData = dmem[dataAddr[10:3]];

    always @(posedge clk) begin
        if (rstN && dataWriteMask != 8'b0) begin
            writeCount++;
            for (int i = 0; i < 8; i++) begin
                if (dataWriteMask[i]) begin
                    dmem[dataAddr[10:3]][8*i +: 8] <= dataWriteData[8*i +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rstN && dataReadEn) begin
            readCount++;
        end
    end

    always @(posedge clk) begin
        if (rstN && commitValid) begin
            pcLog.push_back(commitPc);
            if (rdWen) begin
                shadow[rdAddr] = rdData;
            end
        end
    end

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] k, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {k, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] k, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {k[11:5], rs2, rs1, f3, k[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] k, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {k[12], k[10:5], rs2, rs1, f3, k[4:1], k[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] k, input logic [4:0] rd);
        return {k[20], k[10:1], k[11], k[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // old word with n bytes of val placed from the given lane upward
    function automatic logic [XLEN-1:0] mergeBytes(input logic [XLEN-1:0] old, val,
                                                   input int lane, n);
        logic [XLEN-1:0] res;
        res = old;
        for (int i = 0; i < n; i++) begin
            res[8*(lane+i) +: 8] = val[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [XLEN-1:0] loadValue(input logic [XLEN-1:0] word, input int lane,
                                                  input int n, input logic signExt);
        logic [XLEN-1:0] res;
        res = word >> (8 * lane);
        for (int i = n * 8; i < XLEN; i++) begin
            res[i] = signExt & res[n*8-1];
        end
        return res;
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [XLEN-1:0] a, b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic checkEq(input string what, input logic [XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            testErrors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clearMemories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = EBREAK; // a runaway program halts
            dmem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i)};
        end
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        pcLog.delete();
        expRd.delete();
        expVal.delete();
        cursor = 0;
        testErrors = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[cursor] = word;
        cursor++;
    endtask

    task automatic expectOp(input logic [31:0] word, input int rd, input logic [XLEN-1:0] v);
        emit(word);
        expRd.push_back(rd);
        expVal.push_back(v);
    endtask

    task automatic runProgram();
        int cycles;
        @(negedge clk);
        rstN = 1'b0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        cycles = 0;
        while (!halted && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            errors++;
            testErrors++;
            $display("timeout: halted never rose within 200 cycles");
        end
        foreach (expRd[i]) begin
            checkEq($sformatf("x%0d", expRd[i]), shadow[expRd[i]], expVal[i]);
        end
    endtask

    task automatic reportTest(input string name);
        if (testErrors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, testErrors);
        end
    endtask

    task automatic aluOps();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [11:0]     k;
        logic [XLEN-1:0] kx;
        logic [5:0]      sh;
        logic [5:0]      sk;
        clearMemories();
        a = rand64();
        b = rand64();
        k = 12'($random(seed));
        kx = {{52{k[11]}}, k};
        sh = b[5:0];
        sk = k[5:0];
        dmem[0] = a;
        dmem[1] = b;
        emit(iType(0, 0, 3, 1, OP_LOAD));
        emit(iType(8, 0, 3, 2, OP_LOAD));
        expectOp(rType(0, 2, 1, 0, 3, OP_REG), 3, a + b);
        expectOp(rType(7'h20, 2, 1, 0, 4, OP_REG), 4, a - b);
        expectOp(rType(0, 2, 1, 4, 5, OP_REG), 5, a ^ b);
        expectOp(rType(0, 2, 1, 6, 6, OP_REG), 6, a | b);
        expectOp(rType(0, 2, 1, 7, 7, OP_REG), 7, a & b);
        expectOp(rType(0, 2, 1, 1, 8, OP_REG), 8, a << sh);
        expectOp(rType(0, 2, 1, 5, 9, OP_REG), 9, a >> sh);
        expectOp(rType(7'h20, 2, 1, 5, 10, OP_REG), 10, $signed(a) >>> sh);
        expectOp(rType(0, 2, 1, 2, 11, OP_REG), 11, $signed(a) < $signed(b));
        expectOp(rType(0, 2, 1, 3, 12, OP_REG), 12, a < b);
        expectOp(iType(k, 1, 0, 13, OP_IMM), 13, a + kx);
        expectOp(iType(k, 1, 4, 14, OP_IMM), 14, a ^ kx);
        expectOp(iType(k, 1, 6, 15, OP_IMM), 15, a | kx);
        expectOp(iType(k, 1, 7, 16, OP_IMM), 16, a & kx);
        expectOp(iType(k, 1, 2, 17, OP_IMM), 17, $signed(a) < $signed(kx));
        expectOp(iType(k, 1, 3, 18, OP_IMM), 18, a < kx);
        expectOp(iType({6'h00, sk}, 1, 1, 19, OP_IMM), 19, a << sk);
        expectOp(iType({6'h00, sk}, 1, 5, 20, OP_IMM), 20, a >> sk);
        expectOp(iType({6'h10, sk}, 1, 5, 21, OP_IMM), 21, $signed(a) >>> sk);
        emit(rType(0, 2, 1, 0, 0, OP_REG)); // add x0, x1, x2
        expectOp(rType(0, 0, 0, 0, 22, OP_REG), 22, 0);
        runProgram();
        reportTest("aluOps");
    endtask

    task automatic wordAndMulDiv();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        clearMemories();
        a = rand64();
        b = rand64() | 64'd1; // nonzero divisor
        dmem[0] = a;
        dmem[1] = b;
        dmem[2] = {1'b1, 63'b0};
        dmem[3] = '1;
        emit(iType(0, 0, 3, 1, OP_LOAD));
        emit(iType(8, 0, 3, 2, OP_LOAD));
        emit(iType(16, 0, 3, 16, OP_LOAD));
        emit(iType(24, 0, 3, 17, OP_LOAD));
        expectOp(rType(0, 2, 1, 0, 3, OP_REG32), 3, sext32(a[31:0] + b[31:0]));
        expectOp(rType(7'h20, 2, 1, 0, 4, OP_REG32), 4, sext32(a[31:0] - b[31:0]));
        expectOp(rType(0, 2, 1, 1, 5, OP_REG32), 5, sext32(a[31:0] << b[4:0]));
        expectOp(iType(7, 1, 5, 6, OP_IMM32), 6, sext32(a[31:0] >> 7));
        expectOp(rType(1, 2, 1, 0, 7, OP_REG32), 7, sext32(a[31:0] * b[31:0]));
        expectOp(rType(1, 2, 1, 4, 8, OP_REG), 8, $signed(a) / $signed(b));
        expectOp(rType(1, 2, 1, 5, 9, OP_REG), 9, a / b);
        expectOp(rType(1, 2, 1, 6, 10, OP_REG), 10, $signed(a) % $signed(b));
        expectOp(rType(1, 2, 1, 7, 11, OP_REG), 11, a % b);
        expectOp(rType(1, 0, 1, 4, 12, OP_REG), 12, '1);
        expectOp(rType(1, 0, 1, 5, 13, OP_REG), 13, '1);
        expectOp(rType(1, 0, 1, 6, 14, OP_REG), 14, a);
        expectOp(rType(1, 0, 1, 7, 15, OP_REG), 15, a);
        expectOp(rType(1, 17, 16, 4, 18, OP_REG), 18, {1'b1, 63'b0});
        expectOp(rType(1, 17, 16, 6, 19, OP_REG), 19, 0);
        runProgram();
        reportTest("wordAndMulDiv");
    endtask

    task automatic loadStore();
        logic [XLEN-1:0] s;
        logic [XLEN-1:0] c;
        logic [XLEN-1:0] old [8];
        int              readsBefore;
        clearMemories();
        s = rand64();
        c = rand64() | 64'h8080_8080_8080_8080; // every byte negative
        dmem[0] = s;
        dmem[6] = c;
        for (int i = 0; i < 8; i++) begin
            old[i] = dmem[i];
        end
        emit(iType(0, 0, 3, 1, OP_LOAD));
        emit(sType(17, 1, 0, 0));
        emit(sType(26, 1, 0, 1));
        emit(sType(36, 1, 0, 2));
        emit(sType(40, 1, 0, 3));
        expectOp(iType(51, 0, 0, 2, OP_LOAD), 2, loadValue(c, 3, 1, 1));
        expectOp(iType(50, 0, 1, 3, OP_LOAD), 3, loadValue(c, 2, 2, 1));
        expectOp(iType(52, 0, 2, 4, OP_LOAD), 4, loadValue(c, 4, 4, 1));
        expectOp(iType(48, 0, 3, 5, OP_LOAD), 5, c);
        expectOp(iType(55, 0, 4, 6, OP_LOAD), 6, loadValue(c, 7, 1, 0));
        expectOp(iType(54, 0, 5, 7, OP_LOAD), 7, loadValue(c, 6, 2, 0));
        expectOp(iType(40, 0, 3, 8, OP_LOAD), 8, s);
        readsBefore = readCount;
        runProgram();
        checkEq("data reads", readCount - readsBefore, 8); // one strobe per load
        checkEq("dmem[1]", dmem[1], old[1]);
        checkEq("dmem[2] after sb", dmem[2], mergeBytes(old[2], s, 1, 1));
        checkEq("dmem[3] after sh", dmem[3], mergeBytes(old[3], s, 2, 2));
        checkEq("dmem[4] after sw", dmem[4], mergeBytes(old[4], s, 4, 4));
        checkEq("dmem[5] after sd", dmem[5], s);
        checkEq("dmem[7]", dmem[7], old[7]);
        reportTest("loadStore");
    endtask

    task automatic controlFlow();
        logic [XLEN-1:0] expPc [$];
        logic [XLEN-1:0] va;
        logic [XLEN-1:0] vb;
        logic [2:0]      f3;
        int              p;
        int              notTaken;
        clearMemories();
        notTaken = 0;
        emit(iType(5, 0, 0, 1, OP_IMM));
        emit(iType(12'hffd, 0, 0, 2, OP_IMM)); // x2 = -3
        expPc = {0, 4};
        for (int t = 0; t < 6; t++) begin
            for (int pr = 0; pr < 3; pr++) begin
                f3 = (t < 2) ? 3'(t) : 3'(t + 2);
                va = (pr == 1) ? -64'sd3 : 64'd5;
                vb = (pr == 0) ? -64'sd3 : 64'd5;
                p = cursor * 4;
                emit(bType(8, (pr == 0) ? 2 : 1, (pr == 1) ? 2 : 1, f3));
                emit(iType(1, 10, 0, 10, OP_IMM)); // skipped when taken
                expPc.push_back(p);
                if (!branchTaken(f3, va, vb)) begin
                    expPc.push_back(p + 4);
                    notTaken++;
                end
            end
        end
        p = cursor * 4;
        expectOp(jType(12, 5), 5, p + 4);
        emit(iType(1, 11, 0, 11, OP_IMM));
        emit(iType(1, 11, 0, 11, OP_IMM));
        expPc.push_back(p);
        p = p + 12;
        emit(iType(12'(p + 16), 0, 0, 6, OP_IMM));
        expectOp(iType(1, 6, 0, 7, OP_JALR), 7, p + 8); // odd target, bit 0 dropped
        emit(iType(1, 12, 0, 12, OP_IMM));
        emit(iType(1, 12, 0, 12, OP_IMM));
        emit(EBREAK);
        expPc.push_back(p);
        expPc.push_back(p + 4);
        expPc.push_back(p + 16);
        expRd.push_back(10);
        expVal.push_back(notTaken);
        runProgram();
        checkEq("commit count", pcLog.size(), expPc.size());
        for (int i = 0; i < expPc.size() && i < pcLog.size(); i++) begin
            checkEq($sformatf("commitPc %0d", i), pcLog[i], expPc[i]);
        end
        reportTest("controlFlow");
    endtask

    task automatic upperImm();
        logic [19:0] u1;
        logic [19:0] u2;
        clearMemories();
        u1 = 20'($random(seed)) | 20'h80000;
        u2 = 20'($random(seed)) & 20'h7ffff;
        expectOp({u1, 5'd1, OP_LUI}, 1, {{32{u1[19]}}, u1, 12'b0});
        expectOp({u1, 5'd2, OP_AUIPC}, 2, 64'd4 + {{32{u1[19]}}, u1, 12'b0});
        expectOp({u2, 5'd3, OP_LUI}, 3, {32'b0, u2, 12'b0});
        expectOp({u2, 5'd4, OP_AUIPC}, 4, 64'd12 + {32'b0, u2, 12'b0});
        runProgram();
        reportTest("upperImm");
    endtask

    task automatic haltStops();
        int writesBefore;
        clearMemories();
        emit(iType(12'h055, 0, 0, 1, OP_IMM));
        emit(EBREAK);
        emit(sType(0, 1, 0, 3)); // sd that must never reach memory
        runProgram();
        writesBefore = writeCount;
        checkEq("halted", halted, 1);
        repeat (10) begin
            @(negedge clk);
            checkEq("commitValid after halt", commitValid, 0);
        end
        checkEq("halted held", halted, 1);
        checkEq("data writes after halt", writeCount, writesBefore);
        checkEq("commits up to halt", pcLog.size(), 2);
        checkEq("dmem[0]", dmem[0], {32'h0, 32'hffff_ffff});
        reportTest("haltStops");
    endtask

    initial begin
        rstN = 1'b0;
        clearMemories();
        aluOps();
        wordAndMulDiv();
        loadStore();
        controlFlow();
        upperImm();
        haltStops();
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/coreDefs.sv
rtl/fetchStage.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/execStage.sv
rtl/memStage.sv
rtl/rvCore.sv
bench/coreTb.sv
